// File: project.f
cce_src_pkg.sv
cce_operand_sel.sv
cce_addr_sel.sv
cce_lce_sel.sv
cce_way_sel.sv
cce_coh_state_sel.sv
cce_src_sel.sv
cce_src_sel_props.sv
tb_cce_src_sel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cce_src_sel
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cce_src_sel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cce_src_sel;

  logic                                     clk;
  logic                                     rst_n;
  cce_src_pkg::inst_sel_s                   inst;
  cce_src_pkg::gpr_file_t                   gpr;
  cce_src_pkg::mshr_s                       mshr;
  cce_src_pkg::queue_s                      queue;
  cce_src_pkg::sharers_s                    sharers;
  logic [cce_src_pkg::cce_id_width_lp-1:0]  cce_id;
  logic                                     auto_fwd_msg;
  cce_src_pkg::coh_state_e                  coh_state_default;
  logic [cce_src_pkg::gpr_width_lp-1:0]     src_a;
  logic [cce_src_pkg::gpr_width_lp-1:0]     src_b;
  logic [cce_src_pkg::paddr_width_lp-1:0]   addr;
  logic                                     addr_bypass;
  logic [cce_src_pkg::lce_id_width_lp-1:0]  lce;
  logic [cce_src_pkg::way_width_lp-1:0]     way;
  logic [cce_src_pkg::way_width_lp-1:0]     lru_way;
  cce_src_pkg::coh_state_e                  state;

  cce_src_sel UUT (
    .inst_i                (inst)
    , .gpr_i               (gpr)
    , .mshr_i              (mshr)
    , .queue_i             (queue)
    , .sharers_i           (sharers)
    , .cce_id_i            (cce_id)
    , .auto_fwd_msg_i      (auto_fwd_msg)
    , .coh_state_default_i (coh_state_default)
    , .src_a_o             (src_a)
    , .src_b_o             (src_b)
    , .addr_o              (addr)
    , .addr_bypass_o       (addr_bypass)
    , .lce_o               (lce)
    , .way_o               (way)
    , .lru_way_o           (lru_way)
    , .state_o             (state)
  );

  bind cce_src_sel cce_src_sel_props u_props (
    .clk_i           (tb_cce_src_sel.clk)
    , .rst_n_i       (tb_cce_src_sel.rst_n)
    , .inst_i        (inst_i)
    , .src_a_i       (src_a_o)
    , .src_b_i       (src_b_o)
    , .addr_bypass_i (addr_bypass_o)
    , .state_i       (state_o)
  );

  always #20 clk = ~clk;

  function automatic logic [511:0] random_bits();
    logic [511:0] v;
    for (int i = 0; i < 16; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  task automatic drive_random_inputs();
    logic [511:0] r;
    r = random_bits();
    gpr = cce_src_pkg::gpr_file_t'(r);
    r = random_bits();
    mshr = cce_src_pkg::mshr_s'(r[$bits(cce_src_pkg::mshr_s)-1:0]);
    r = random_bits();
    queue = cce_src_pkg::queue_s'(r[$bits(cce_src_pkg::queue_s)-1:0]);
    r = random_bits();
    sharers = cce_src_pkg::sharers_s'(r[$bits(cce_src_pkg::sharers_s)-1:0]);
    // full code range, so undefined selects show up too
    inst.src_a_sel = cce_src_pkg::src_sel_e'(3'($urandom_range(0, 7)));
    inst.src_a = 4'($urandom_range(0, 15));
    inst.src_b_sel = cce_src_pkg::src_sel_e'(3'($urandom_range(0, 7)));
    inst.src_b = 4'($urandom_range(0, 15));
    inst.addr_sel = cce_src_pkg::addr_sel_e'(4'($urandom_range(0, 15)));
    inst.lce_sel = cce_src_pkg::lce_sel_e'(4'($urandom_range(0, 15)));
    inst.way_sel = cce_src_pkg::way_sel_e'(4'($urandom_range(0, 15)));
    inst.lru_way_sel = cce_src_pkg::way_sel_e'(4'($urandom_range(0, 15)));
    inst.coh_sel = cce_src_pkg::coh_sel_e'(4'($urandom_range(0, 15)));
    inst.imm = {$urandom, $urandom};
    cce_id = 1'($urandom);
    auto_fwd_msg = 1'($urandom);
    coh_state_default = cce_src_pkg::coh_state_e'(3'($urandom));
  endtask

  // sharer slot named by the low bits of a register
  function automatic logic [2:0] sharer_slot(input logic [3:0] code);
    return gpr[code[2:0]][2:0];
  endfunction

  function automatic logic [63:0] expect_operand(input logic [2:0] sel, input logic [3:0] opd,
                                                 input logic [3:0] sh_opd, input bit sh_en);
    logic [63:0] v;
    logic [2:0]  sh;
    v = '0;
    sh = sharer_slot(sh_opd);
    case (sel)
      cce_src_pkg::e_src_sel_gpr: v = gpr[opd[2:0]];
      cce_src_pkg::e_src_sel_flag: begin
        if (opd < 4'd13)
          v[0] = mshr.flags[opd];
      end
      cce_src_pkg::e_src_sel_special: begin
        case (opd)
          cce_src_pkg::e_spec_req_lce:         v = 64'(mshr.lce_id);
          cce_src_pkg::e_spec_req_addr:        v = 64'(mshr.paddr);
          cce_src_pkg::e_spec_req_way:         v = 64'(mshr.way_id);
          cce_src_pkg::e_spec_lru_addr:        v = 64'(mshr.lru_paddr);
          cce_src_pkg::e_spec_lru_way:         v = 64'(mshr.lru_way_id);
          cce_src_pkg::e_spec_owner_lce:       v = 64'(mshr.owner_lce_id);
          cce_src_pkg::e_spec_owner_way:       v = 64'(mshr.owner_way_id);
          cce_src_pkg::e_spec_next_coh_state:  v = 64'(mshr.next_coh_state);
          cce_src_pkg::e_spec_flags:           v = 64'(mshr.flags & inst.imm[12:0]);
          cce_src_pkg::e_spec_lru_coh_state:   v = 64'(mshr.lru_coh_state);
          cce_src_pkg::e_spec_owner_coh_state: v = 64'(mshr.owner_coh_state);
          cce_src_pkg::e_spec_sharers_hit:     v = sh_en ? 64'(sharers.hits[sh]) : '0;
          cce_src_pkg::e_spec_sharers_way:     v = sh_en ? 64'(sharers.ways[sh]) : '0;
          cce_src_pkg::e_spec_sharers_state:   v = sh_en ? 64'(sharers.states[sh]) : '0;
          default: v = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_param: begin
        case (opd[2:0])
          cce_src_pkg::e_param_cce_id:            v = 64'(cce_id);
          cce_src_pkg::e_param_num_lce:           v = 64'd8;
          cce_src_pkg::e_param_num_cce:           v = 64'd2;
          cce_src_pkg::e_param_num_wg:            v = 64'd64;
          cce_src_pkg::e_param_auto_fwd_msg:      v = 64'(auto_fwd_msg);
          cce_src_pkg::e_param_coh_state_default: v = 64'(coh_state_default);
          default: v = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_queue: begin
        case (opd)
          cce_src_pkg::e_q_mem_resp_v:    v = 64'(queue.mem_resp_v);
          cce_src_pkg::e_q_lce_resp_v:    v = 64'(queue.lce_resp_v);
          cce_src_pkg::e_q_lce_req_v:     v = 64'(queue.lce_req_v);
          cce_src_pkg::e_q_lce_resp_type: v = 64'(queue.lce_resp.msg_type);
          cce_src_pkg::e_q_mem_resp_type: v = 64'(queue.mem_resp.msg_type);
          cce_src_pkg::e_q_lce_resp_data: v = queue.lce_resp_data;
          cce_src_pkg::e_q_mem_resp_data: v = queue.mem_resp_data;
          cce_src_pkg::e_q_lce_req_data:  v = queue.lce_req_data;
          default: v = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_imm: v = inst.imm;
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [63:0] expect_addr(input logic [3:0] sel);
    if (sel < 4'd8)
      return 64'(gpr[sel[2:0]][39:0]);
    case (sel)
      cce_src_pkg::e_addr_mshr_req: return 64'(mshr.paddr);
      cce_src_pkg::e_addr_mshr_lru: return 64'(mshr.lru_paddr);
      cce_src_pkg::e_addr_lce_req:  return 64'(queue.lce_req.addr);
      cce_src_pkg::e_addr_lce_resp: return 64'(queue.lce_resp.addr);
      cce_src_pkg::e_addr_mem_resp: return 64'(queue.mem_resp.addr);
      default: return '0;
    endcase
  endfunction

  function automatic logic [63:0] expect_lce(input logic [3:0] sel);
    if (sel < 4'd8)
      return 64'(gpr[sel[2:0]][3:0]);
    case (sel)
      cce_src_pkg::e_lce_mshr_req:   return 64'(mshr.lce_id);
      cce_src_pkg::e_lce_mshr_owner: return 64'(mshr.owner_lce_id);
      cce_src_pkg::e_lce_lce_req:    return 64'(queue.lce_req.src_id);
      cce_src_pkg::e_lce_lce_resp:   return 64'(queue.lce_resp.src_id);
      cce_src_pkg::e_lce_mem_resp:   return 64'(queue.mem_resp.lce_id);
      default: return '0;
    endcase
  endfunction

  function automatic logic [63:0] expect_way(input logic [3:0] sel);
    if (sel < 4'd8)
      return 64'(gpr[sel[2:0]][2:0]);
    case (sel)
      cce_src_pkg::e_way_mshr_req:   return 64'(mshr.way_id);
      cce_src_pkg::e_way_mshr_owner: return 64'(mshr.owner_way_id);
      cce_src_pkg::e_way_mshr_lru:   return 64'(mshr.lru_way_id);
      cce_src_pkg::e_way_sh_way:     return 64'(sharers.ways[sharer_slot(inst.src_a)]);
      default: return '0;
    endcase
  endfunction

  // undefined codes fall back to I, which encodes as zero
  function automatic logic [63:0] expect_state(input logic [3:0] sel);
    if (sel < 4'd8)
      return 64'(gpr[sel[2:0]][2:0]);
    case (sel)
      cce_src_pkg::e_coh_sel_next_coh_state:  return 64'(mshr.next_coh_state);
      cce_src_pkg::e_coh_sel_lru_coh_state:   return 64'(mshr.lru_coh_state);
      cce_src_pkg::e_coh_sel_sharer_state:    return 64'(sharers.states[sharer_slot(inst.src_a)]);
      cce_src_pkg::e_coh_sel_owner_coh_state: return 64'(mshr.owner_coh_state);
      cce_src_pkg::e_coh_sel_inst_imm:        return 64'(inst.imm[2:0]);
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_outputs();
    logic bypass_exp;
    bypass_exp = (inst.addr_sel < 4'd8) || (inst.addr_sel == cce_src_pkg::e_addr_zero);
    check_value("src_a_o", src_a, expect_operand(inst.src_a_sel, inst.src_a, inst.src_b, 1'b1));
    check_value("src_b_o", src_b, expect_operand(inst.src_b_sel, inst.src_b, inst.src_a, 1'b0));
    check_value("addr_o", 64'(addr), expect_addr(inst.addr_sel));
    check_value("addr_bypass_o", 64'(addr_bypass), 64'(bypass_exp));
    check_value("lce_o", 64'(lce), expect_lce(inst.lce_sel));
    check_value("way_o", 64'(way), expect_way(inst.way_sel));
    check_value("lru_way_o", 64'(lru_way), expect_way(inst.lru_way_sel));
    check_value("state_o", 64'(state), expect_state(inst.coh_sel));
  endtask

  initial begin
    int seed_ret;
    int cycles;
    int n_checks;
    seed_ret = $urandom(32'h126d83f4);
    clk = 1'b0;
    rst_n = 1'b0;
    inst = '0;
    gpr = '0;
    mshr = '0;
    queue = '0;
    sharers = '0;
    cce_id = '0;
    auto_fwd_msg = 1'b0;
    coh_state_default = cce_src_pkg::e_coh_i;
    cycles = 0;
    while (cycles < 3) begin
      @(posedge clk);
      cycles++;
    end
    #2 rst_n = 1'b1;
    n_checks = 0;
    cycles = 0;
    // guard stops the loop if checks stall
    while (n_checks < 5000 && cycles < 6000) begin
      @(posedge clk);
      #2 drive_random_inputs();
      @(negedge clk);
      compare_outputs();
      n_checks++;
      cycles++;
    end
    if (n_checks == 5000) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("timeout after %0d cycles with only %0d checks done", cycles, n_checks);
      $display("Simulation failed");
      $fatal(1, "stimulus loop timed out");
    end
  end

endmodule

`default_nettype wire

// File: cce_src_sel_props.sv
`timescale 1ns/1ps
`default_nettype none

module cce_src_sel_props (
  input  logic                                    clk_i
  , input  logic                                  rst_n_i
  , input  cce_src_pkg::inst_sel_s                inst_i
  , input  logic [cce_src_pkg::gpr_width_lp-1:0]  src_a_i
  , input  logic [cce_src_pkg::gpr_width_lp-1:0]  src_b_i
  , input  logic                                  addr_bypass_i
  , input  cce_src_pkg::coh_state_e               state_i
);

  logic bypass_src;

  // registers and the zero constant skip the directory pipeline
  assign bypass_src = (inst_i.addr_sel <= cce_src_pkg::e_addr_r7)
                      || (inst_i.addr_sel == cce_src_pkg::e_addr_zero);

  bypass_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_bypass_i == bypass_src)
    else $error("address bypass flag does not follow the address source");

  undef_coh_is_i: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (inst_i.coh_sel > cce_src_pkg::e_coh_sel_inst_imm) |-> (state_i == cce_src_pkg::e_coh_i))
    else $error("undefined coherence select did not give state I");

  zero_src_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (inst_i.src_a_sel == cce_src_pkg::e_src_sel_zero) |-> (src_a_i == '0))
    else $error("zero source group gave a nonzero source A");

  zero_src_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (inst_i.src_b_sel == cce_src_pkg::e_src_sel_zero) |-> (src_b_i == '0))
    else $error("zero source group gave a nonzero source B");

endmodule

`default_nettype wire

// File: cce_src_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_src_sel (
  input  cce_src_pkg::inst_sel_s                      inst_i
  , input  cce_src_pkg::gpr_file_t                    gpr_i
  , input  cce_src_pkg::mshr_s                        mshr_i
  , input  cce_src_pkg::queue_s                       queue_i
  , input  cce_src_pkg::sharers_s                     sharers_i
  , input  logic [cce_src_pkg::cce_id_width_lp-1:0]   cce_id_i
  , input  logic                                      auto_fwd_msg_i
  , input  cce_src_pkg::coh_state_e                   coh_state_default_i
  , output logic [cce_src_pkg::gpr_width_lp-1:0]      src_a_o
  , output logic [cce_src_pkg::gpr_width_lp-1:0]      src_b_o
  , output logic [cce_src_pkg::paddr_width_lp-1:0]    addr_o
  , output logic                                      addr_bypass_o
  , output logic [cce_src_pkg::lce_id_width_lp-1:0]   lce_o
  , output logic [cce_src_pkg::way_width_lp-1:0]      way_o
  , output logic [cce_src_pkg::way_width_lp-1:0]      lru_way_o
  , output cce_src_pkg::coh_state_e                   state_o
);

  // src_a reads sharers through the gpr named by src_b
  cce_operand_sel #(.sharers_en_p(1'b1)) u_src_a (
    .sel_i               (inst_i.src_a_sel)
    , .opd_i             (inst_i.src_a)
    , .sharer_opd_i      (inst_i.src_b)
    , .imm_i             (inst_i.imm)
    , .gpr_i             (gpr_i)
    , .mshr_i            (mshr_i)
    , .queue_i           (queue_i)
    , .sharers_i         (sharers_i)
    , .cce_id_i          (cce_id_i)
    , .auto_fwd_msg_i    (auto_fwd_msg_i)
    , .coh_state_default_i (coh_state_default_i)
    , .opd_o             (src_a_o)
  );

  // no sharer reads on src_b
  cce_operand_sel #(.sharers_en_p(1'b0)) u_src_b (
    .sel_i               (inst_i.src_b_sel)
    , .opd_i             (inst_i.src_b)
    , .sharer_opd_i      (inst_i.src_a)
    , .imm_i             (inst_i.imm)
    , .gpr_i             (gpr_i)
    , .mshr_i            (mshr_i)
    , .queue_i           (queue_i)
    , .sharers_i         (sharers_i)
    , .cce_id_i          (cce_id_i)
    , .auto_fwd_msg_i    (auto_fwd_msg_i)
    , .coh_state_default_i (coh_state_default_i)
    , .opd_o             (src_b_o)
  );

  cce_addr_sel u_addr (
    .sel_i           (inst_i.addr_sel)
    , .gpr_i         (gpr_i)
    , .mshr_i        (mshr_i)
    , .queue_i       (queue_i)
    , .addr_o        (addr_o)
    , .addr_bypass_o (addr_bypass_o)
  );

  cce_lce_sel u_lce (
    .sel_i     (inst_i.lce_sel)
    , .gpr_i   (gpr_i)
    , .mshr_i  (mshr_i)
    , .queue_i (queue_i)
    , .lce_o   (lce_o)
  );

  cce_way_sel u_way (
    .sel_i          (inst_i.way_sel)
    , .sharer_opd_i (inst_i.src_a)
    , .gpr_i        (gpr_i)
    , .mshr_i       (mshr_i)
    , .sharers_i    (sharers_i)
    , .way_o        (way_o)
  );

  cce_way_sel u_lru_way (
    .sel_i          (inst_i.lru_way_sel)
    , .sharer_opd_i (inst_i.src_a)
    , .gpr_i        (gpr_i)
    , .mshr_i       (mshr_i)
    , .sharers_i    (sharers_i)
    , .way_o        (lru_way_o)
  );

  cce_coh_state_sel u_state (
    .sel_i          (inst_i.coh_sel)
    , .sharer_opd_i (inst_i.src_a)
    , .imm_i        (inst_i.imm)
    , .gpr_i        (gpr_i)
    , .mshr_i       (mshr_i)
    , .sharers_i    (sharers_i)
    , .state_o      (state_o)
  );

endmodule

`default_nettype wire

// File: cce_coh_state_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_coh_state_sel (
  input  cce_src_pkg::coh_sel_e                   sel_i
  , input  cce_src_pkg::src_opd_t                 sharer_opd_i
  , input  logic [cce_src_pkg::gpr_width_lp-1:0]  imm_i
  , input  cce_src_pkg::gpr_file_t                gpr_i
  , input  cce_src_pkg::mshr_s                    mshr_i
  , input  cce_src_pkg::sharers_s                 sharers_i
  , output cce_src_pkg::coh_state_e               state_o
);

  logic [cce_src_pkg::lg_num_lce_lp-1:0] sh_idx;

  assign sh_idx =
    gpr_i[sharer_opd_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::lg_num_lce_lp-1:0];

  always_comb begin
    unique case (sel_i)
      cce_src_pkg::e_coh_sel_r0, cce_src_pkg::e_coh_sel_r1,
      cce_src_pkg::e_coh_sel_r2, cce_src_pkg::e_coh_sel_r3,
      cce_src_pkg::e_coh_sel_r4, cce_src_pkg::e_coh_sel_r5,
      cce_src_pkg::e_coh_sel_r6, cce_src_pkg::e_coh_sel_r7:
        state_o = cce_src_pkg::coh_state_e'(
          gpr_i[sel_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::coh_state_width_lp-1:0]);
      cce_src_pkg::e_coh_sel_next_coh_state:  state_o = mshr_i.next_coh_state;
      cce_src_pkg::e_coh_sel_lru_coh_state:   state_o = mshr_i.lru_coh_state;
      cce_src_pkg::e_coh_sel_sharer_state:    state_o = sharers_i.states[sh_idx];
      cce_src_pkg::e_coh_sel_owner_coh_state: state_o = mshr_i.owner_coh_state;
      cce_src_pkg::e_coh_sel_inst_imm:
        state_o = cce_src_pkg::coh_state_e'(imm_i[cce_src_pkg::coh_state_width_lp-1:0]);
      // invalid is the safe state
      default: state_o = cce_src_pkg::e_coh_i;
    endcase
  end

endmodule

`default_nettype wire

// File: cce_way_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_way_sel (
  input  cce_src_pkg::way_sel_e                   sel_i
  , input  cce_src_pkg::src_opd_t                 sharer_opd_i
  , input  cce_src_pkg::gpr_file_t                gpr_i
  , input  cce_src_pkg::mshr_s                    mshr_i
  , input  cce_src_pkg::sharers_s                 sharers_i
  , output logic [cce_src_pkg::way_width_lp-1:0]  way_o
);

  logic [cce_src_pkg::lg_num_lce_lp-1:0] sh_idx;

  assign sh_idx =
    gpr_i[sharer_opd_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::lg_num_lce_lp-1:0];

  always_comb begin
    unique case (sel_i)
      cce_src_pkg::e_way_r0, cce_src_pkg::e_way_r1,
      cce_src_pkg::e_way_r2, cce_src_pkg::e_way_r3,
      cce_src_pkg::e_way_r4, cce_src_pkg::e_way_r5,
      cce_src_pkg::e_way_r6, cce_src_pkg::e_way_r7:
        way_o = gpr_i[sel_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::way_width_lp-1:0];
      cce_src_pkg::e_way_mshr_req:   way_o = mshr_i.way_id;
      cce_src_pkg::e_way_mshr_owner: way_o = mshr_i.owner_way_id;
      cce_src_pkg::e_way_mshr_lru:   way_o = mshr_i.lru_way_id;
      // way held by the sharer a gpr points at
      cce_src_pkg::e_way_sh_way:     way_o = sharers_i.ways[sh_idx];
      default: way_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: cce_lce_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_lce_sel (
  input  cce_src_pkg::lce_sel_e                      sel_i
  , input  cce_src_pkg::gpr_file_t                   gpr_i
  , input  cce_src_pkg::mshr_s                       mshr_i
  , input  cce_src_pkg::queue_s                      queue_i
  , output logic [cce_src_pkg::lce_id_width_lp-1:0]  lce_o
);

  always_comb begin
    unique case (sel_i)
      cce_src_pkg::e_lce_r0, cce_src_pkg::e_lce_r1,
      cce_src_pkg::e_lce_r2, cce_src_pkg::e_lce_r3,
      cce_src_pkg::e_lce_r4, cce_src_pkg::e_lce_r5,
      cce_src_pkg::e_lce_r6, cce_src_pkg::e_lce_r7:
        lce_o = gpr_i[sel_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::lce_id_width_lp-1:0];
      cce_src_pkg::e_lce_mshr_req:   lce_o = mshr_i.lce_id;
      cce_src_pkg::e_lce_mshr_owner: lce_o = mshr_i.owner_lce_id;
      // requesting lce of each message
      cce_src_pkg::e_lce_lce_req:    lce_o = queue_i.lce_req.src_id;
      cce_src_pkg::e_lce_lce_resp:   lce_o = queue_i.lce_resp.src_id;
      cce_src_pkg::e_lce_mem_resp:   lce_o = queue_i.mem_resp.lce_id;
      default: lce_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: cce_addr_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_addr_sel (
  input  cce_src_pkg::addr_sel_e                    sel_i
  , input  cce_src_pkg::gpr_file_t                  gpr_i
  , input  cce_src_pkg::mshr_s                      mshr_i
  , input  cce_src_pkg::queue_s                     queue_i
  , output logic [cce_src_pkg::paddr_width_lp-1:0]  addr_o
  , output logic                                    addr_bypass_o
);

  always_comb begin
    unique case (sel_i)
      cce_src_pkg::e_addr_r0, cce_src_pkg::e_addr_r1,
      cce_src_pkg::e_addr_r2, cce_src_pkg::e_addr_r3,
      cce_src_pkg::e_addr_r4, cce_src_pkg::e_addr_r5,
      cce_src_pkg::e_addr_r6, cce_src_pkg::e_addr_r7:
        addr_o = gpr_i[sel_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::paddr_width_lp-1:0];
      cce_src_pkg::e_addr_mshr_req: addr_o = mshr_i.paddr;
      cce_src_pkg::e_addr_mshr_lru: addr_o = mshr_i.lru_paddr;
      cce_src_pkg::e_addr_lce_req:  addr_o = queue_i.lce_req.addr;
      cce_src_pkg::e_addr_lce_resp: addr_o = queue_i.lce_resp.addr;
      cce_src_pkg::e_addr_mem_resp: addr_o = queue_i.mem_resp.addr;
      default: addr_o = '0;
    endcase
  end

  // directory lookup can skip the pipeline for register or constant sources
  always_comb begin
    unique case (sel_i)
      cce_src_pkg::e_addr_r0, cce_src_pkg::e_addr_r1,
      cce_src_pkg::e_addr_r2, cce_src_pkg::e_addr_r3,
      cce_src_pkg::e_addr_r4, cce_src_pkg::e_addr_r5,
      cce_src_pkg::e_addr_r6, cce_src_pkg::e_addr_r7,
      cce_src_pkg::e_addr_zero:
        addr_bypass_o = 1'b1;
      default: addr_bypass_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: cce_operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module cce_operand_sel #(
  parameter bit sharers_en_p = 1'b1
) (
  input  cce_src_pkg::src_sel_e                       sel_i
  , input  cce_src_pkg::src_opd_t                     opd_i
  , input  cce_src_pkg::src_opd_t                     sharer_opd_i
  , input  logic [cce_src_pkg::gpr_width_lp-1:0]      imm_i
  , input  cce_src_pkg::gpr_file_t                    gpr_i
  , input  cce_src_pkg::mshr_s                        mshr_i
  , input  cce_src_pkg::queue_s                       queue_i
  , input  cce_src_pkg::sharers_s                     sharers_i
  , input  logic [cce_src_pkg::cce_id_width_lp-1:0]   cce_id_i
  , input  logic                                      auto_fwd_msg_i
  , input  cce_src_pkg::coh_state_e                   coh_state_default_i
  , output logic [cce_src_pkg::gpr_width_lp-1:0]      opd_o
);

  logic [cce_src_pkg::lg_num_lce_lp-1:0] sh_idx;

  // sharer picked by the low bits of a gpr
  assign sh_idx =
    gpr_i[sharer_opd_i[cce_src_pkg::gpr_sel_width_lp-1:0]][cce_src_pkg::lg_num_lce_lp-1:0];

  always_comb begin
    opd_o = '0;
    unique case (sel_i)
      cce_src_pkg::e_src_sel_gpr:
        opd_o = gpr_i[opd_i[cce_src_pkg::gpr_sel_width_lp-1:0]];
      cce_src_pkg::e_src_sel_flag: begin
        if (opd_i <= cce_src_pkg::e_flag_uf)
          opd_o[0] = mshr_i.flags[opd_i];
      end
      cce_src_pkg::e_src_sel_special: begin
        unique case (cce_src_pkg::special_opd_e'(opd_i))
          cce_src_pkg::e_spec_req_lce:         opd_o[3:0] = mshr_i.lce_id;
          cce_src_pkg::e_spec_req_addr:        opd_o[39:0] = mshr_i.paddr;
          cce_src_pkg::e_spec_req_way:         opd_o[2:0] = mshr_i.way_id;
          cce_src_pkg::e_spec_lru_addr:        opd_o[39:0] = mshr_i.lru_paddr;
          cce_src_pkg::e_spec_lru_way:         opd_o[2:0] = mshr_i.lru_way_id;
          cce_src_pkg::e_spec_owner_lce:       opd_o[3:0] = mshr_i.owner_lce_id;
          cce_src_pkg::e_spec_owner_way:       opd_o[2:0] = mshr_i.owner_way_id;
          cce_src_pkg::e_spec_next_coh_state:  opd_o[2:0] = mshr_i.next_coh_state;
          cce_src_pkg::e_spec_lru_coh_state:   opd_o[2:0] = mshr_i.lru_coh_state;
          cce_src_pkg::e_spec_owner_coh_state: opd_o[2:0] = mshr_i.owner_coh_state;
          // immediate works as a flag mask
          cce_src_pkg::e_spec_flags:
            opd_o[cce_src_pkg::num_flags_lp-1:0] =
              mshr_i.flags & imm_i[cce_src_pkg::num_flags_lp-1:0];
          cce_src_pkg::e_spec_sharers_hit:
            opd_o[0] = sharers_en_p & sharers_i.hits[sh_idx];
          cce_src_pkg::e_spec_sharers_way: begin
            if (sharers_en_p)
              opd_o[cce_src_pkg::way_width_lp-1:0] = sharers_i.ways[sh_idx];
          end
          cce_src_pkg::e_spec_sharers_state: begin
            if (sharers_en_p)
              opd_o[cce_src_pkg::coh_state_width_lp-1:0] = sharers_i.states[sh_idx];
          end
          default: opd_o = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_param: begin
        unique case (cce_src_pkg::param_opd_e'(opd_i[2:0]))
          cce_src_pkg::e_param_cce_id:
            opd_o[cce_src_pkg::cce_id_width_lp-1:0] = cce_id_i;
          cce_src_pkg::e_param_num_lce:
            opd_o[cce_src_pkg::lce_id_width_lp-1:0] =
              cce_src_pkg::lce_id_width_lp'(cce_src_pkg::num_lce_lp);
          cce_src_pkg::e_param_num_cce:
            opd_o[cce_src_pkg::cce_id_width_lp:0] =
              (cce_src_pkg::cce_id_width_lp+1)'(cce_src_pkg::num_cce_lp);
          // one extra bit so the count itself fits
          cce_src_pkg::e_param_num_wg:
            opd_o[cce_src_pkg::lg_num_way_groups_lp:0] =
              (cce_src_pkg::lg_num_way_groups_lp+1)'(cce_src_pkg::num_way_groups_lp);
          cce_src_pkg::e_param_auto_fwd_msg:      opd_o[0] = auto_fwd_msg_i;
          cce_src_pkg::e_param_coh_state_default: opd_o[2:0] = coh_state_default_i;
          default: opd_o = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_queue: begin
        unique case (cce_src_pkg::queue_opd_e'(opd_i))
          cce_src_pkg::e_q_mem_resp_v:    opd_o[0] = queue_i.mem_resp_v;
          cce_src_pkg::e_q_lce_resp_v:    opd_o[0] = queue_i.lce_resp_v;
          cce_src_pkg::e_q_lce_req_v:     opd_o[0] = queue_i.lce_req_v;
          cce_src_pkg::e_q_lce_resp_type: opd_o[3:0] = queue_i.lce_resp.msg_type;
          cce_src_pkg::e_q_mem_resp_type: opd_o[3:0] = queue_i.mem_resp.msg_type;
          cce_src_pkg::e_q_lce_resp_data: opd_o = queue_i.lce_resp_data;
          cce_src_pkg::e_q_mem_resp_data: opd_o = queue_i.mem_resp_data;
          cce_src_pkg::e_q_lce_req_data:  opd_o = queue_i.lce_req_data;
          default: opd_o = '0;
        endcase
      end
      cce_src_pkg::e_src_sel_imm:  opd_o = imm_i;
      cce_src_pkg::e_src_sel_zero: opd_o = '0;
      default: opd_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: cce_src_pkg.sv
`default_nettype none

package cce_src_pkg;

  localparam int gpr_width_lp         = 64;
  localparam int num_gpr_lp           = 8;
  localparam int gpr_sel_width_lp     = $clog2(num_gpr_lp);
  localparam int paddr_width_lp       = 40;
  localparam int num_lce_lp           = 8;
  localparam int lce_id_width_lp      = 4;
  localparam int lg_num_lce_lp        = $clog2(num_lce_lp);
  localparam int lce_assoc_lp         = 8;
  localparam int way_width_lp         = $clog2(lce_assoc_lp);
  localparam int num_cce_lp           = 2;
  localparam int cce_id_width_lp      = $clog2(num_cce_lp);
  localparam int num_way_groups_lp    = 64;
  localparam int lg_num_way_groups_lp = $clog2(num_way_groups_lp);
  localparam int coh_state_width_lp   = 3;
  localparam int num_flags_lp         = 13;

  typedef enum logic [coh_state_width_lp-1:0] {
    e_coh_i = 3'b000, e_coh_s = 3'b001, e_coh_e = 3'b010,
    e_coh_f = 3'b011, e_coh_m = 3'b110, e_coh_o = 3'b111
  } coh_state_e;

  // flag position in mshr_s.flags
  typedef enum logic [3:0] {
    e_flag_rqf, e_flag_ucf, e_flag_nerf, e_flag_nwbf, e_flag_pf, e_flag_sf, e_flag_csf,
    e_flag_cef, e_flag_cmf, e_flag_cof, e_flag_cff, e_flag_rf, e_flag_uf
  } flag_e;

  typedef enum logic [2:0] {
    e_src_sel_gpr, e_src_sel_flag, e_src_sel_special, e_src_sel_param,
    e_src_sel_queue, e_src_sel_imm, e_src_sel_zero
  } src_sel_e;

  typedef enum logic [3:0] {
    e_spec_req_lce, e_spec_req_addr, e_spec_req_way, e_spec_lru_addr, e_spec_lru_way,
    e_spec_owner_lce, e_spec_owner_way, e_spec_next_coh_state, e_spec_flags,
    e_spec_lru_coh_state, e_spec_owner_coh_state, e_spec_sharers_hit,
    e_spec_sharers_way, e_spec_sharers_state
  } special_opd_e;

  typedef enum logic [2:0] {
    e_param_cce_id, e_param_num_lce, e_param_num_cce, e_param_num_wg,
    e_param_auto_fwd_msg, e_param_coh_state_default
  } param_opd_e;

  typedef enum logic [3:0] {
    e_q_mem_resp_v, e_q_lce_resp_v, e_q_lce_req_v, e_q_lce_resp_type,
    e_q_mem_resp_type, e_q_lce_resp_data, e_q_mem_resp_data, e_q_lce_req_data
  } queue_opd_e;

  // gpr index, flag_e, or one of the operand enums, by source group
  typedef logic [3:0] src_opd_t;

  typedef enum logic [3:0] {
    e_addr_r0, e_addr_r1, e_addr_r2, e_addr_r3, e_addr_r4, e_addr_r5, e_addr_r6, e_addr_r7,
    e_addr_mshr_req, e_addr_mshr_lru, e_addr_lce_req, e_addr_lce_resp, e_addr_mem_resp,
    e_addr_zero
  } addr_sel_e;

  typedef enum logic [3:0] {
    e_lce_r0, e_lce_r1, e_lce_r2, e_lce_r3, e_lce_r4, e_lce_r5, e_lce_r6, e_lce_r7,
    e_lce_mshr_req, e_lce_mshr_owner, e_lce_lce_req, e_lce_lce_resp, e_lce_mem_resp,
    e_lce_zero
  } lce_sel_e;

  typedef enum logic [3:0] {
    e_way_r0, e_way_r1, e_way_r2, e_way_r3, e_way_r4, e_way_r5, e_way_r6, e_way_r7,
    e_way_mshr_req, e_way_mshr_owner, e_way_mshr_lru, e_way_sh_way, e_way_zero
  } way_sel_e;

  typedef enum logic [3:0] {
    e_coh_sel_r0, e_coh_sel_r1, e_coh_sel_r2, e_coh_sel_r3,
    e_coh_sel_r4, e_coh_sel_r5, e_coh_sel_r6, e_coh_sel_r7,
    e_coh_sel_next_coh_state, e_coh_sel_lru_coh_state, e_coh_sel_sharer_state,
    e_coh_sel_owner_coh_state, e_coh_sel_inst_imm
  } coh_sel_e;

  typedef logic [num_gpr_lp-1:0][gpr_width_lp-1:0] gpr_file_t;

  typedef struct packed {
    logic [paddr_width_lp-1:0]  paddr;
    logic [paddr_width_lp-1:0]  lru_paddr;
    logic [lce_id_width_lp-1:0] lce_id;
    logic [way_width_lp-1:0]    way_id;
    logic [lce_id_width_lp-1:0] owner_lce_id;
    logic [way_width_lp-1:0]    owner_way_id;
    logic [way_width_lp-1:0]    lru_way_id;
    coh_state_e                 next_coh_state;
    coh_state_e                 lru_coh_state;
    coh_state_e                 owner_coh_state;
    logic [num_flags_lp-1:0]    flags;
  } mshr_s;

  typedef struct packed {
    logic [paddr_width_lp-1:0]  addr;
    logic [3:0]                 msg_type;
    logic [lce_id_width_lp-1:0] src_id;
  } lce_req_hdr_s;

  typedef struct packed {
    logic [paddr_width_lp-1:0]  addr;
    logic [3:0]                 msg_type;
    logic [lce_id_width_lp-1:0] src_id;
  } lce_resp_hdr_s;

  typedef struct packed {
    logic [paddr_width_lp-1:0]  addr;
    logic [3:0]                 msg_type;
    logic [lce_id_width_lp-1:0] lce_id;
  } mem_resp_hdr_s;

  typedef struct packed {
    logic                    lce_req_v;
    logic                    lce_resp_v;
    logic                    mem_resp_v;
    lce_req_hdr_s            lce_req;
    lce_resp_hdr_s           lce_resp;
    mem_resp_hdr_s           mem_resp;
    logic [gpr_width_lp-1:0] lce_req_data;
    logic [gpr_width_lp-1:0] lce_resp_data;
    logic [gpr_width_lp-1:0] mem_resp_data;
  } queue_s;

  typedef struct packed {
    logic [num_lce_lp-1:0]                   hits;
    logic [num_lce_lp-1:0][way_width_lp-1:0] ways;
    coh_state_e [num_lce_lp-1:0]             states;
  } sharers_s;

  typedef struct packed {
    src_sel_e                src_a_sel;
    src_opd_t                src_a;
    src_sel_e                src_b_sel;
    src_opd_t                src_b;
    addr_sel_e               addr_sel;
    lce_sel_e                lce_sel;
    way_sel_e                way_sel;
    way_sel_e                lru_way_sel;
    coh_sel_e                coh_sel;
    logic [gpr_width_lp-1:0] imm;
  } inst_sel_s;

endpackage

`default_nettype wire
